/* alu.sv */
`default_nettype none
`timescale 1ns/100ps

module alu (
    input  logic [rv_isa_pkg::XLEN-1:0] src_a,
    input  logic [rv_isa_pkg::XLEN-1:0] src_b,
    input  logic [pipe_pkg::ALU_OP_W-1:0] alu_op,
    output logic [rv_isa_pkg::XLEN-1:0] result
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic [4:0] shamt;

    assign shamt = src_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                result = src_a + src_b;
            end
            ALU_SUB: begin
                result = src_a - src_b;
            end
            ALU_SLL: begin
                result = src_a << shamt;
            end
            ALU_SLT: begin
                result = {{(XLEN - 1){1'b0}}, ($signed(src_a) < $signed(src_b))};
            end
            ALU_SLTU: begin
                result = {{(XLEN - 1){1'b0}}, (src_a < src_b)};
            end
            ALU_XOR: begin
                result = src_a ^ src_b;
            end
            ALU_SRL: begin
                result = src_a >> shamt;
            end
            ALU_SRA: begin
                // Sign bit fills from the left
                result = $signed(src_a) >>> shamt;
            end
            ALU_OR: begin
                result = src_a | src_b;
            end
            ALU_AND: begin
                result = src_a & src_b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* forward_unit.sv */
`default_nettype none
`timescale 1ns/100ps

module forward_unit (
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] ex_rs1,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] ex_rs2,
    input  logic [rv_isa_pkg::XLEN-1:0] ex_rd1,
    input  logic [rv_isa_pkg::XLEN-1:0] ex_rd2,
    input  logic [rv_isa_pkg::XLEN-1:0] ex_imm,
    input  logic ex_use_imm,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] mem_rd,
    input  logic mem_write,
    input  logic [rv_isa_pkg::XLEN-1:0] mem_result,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] wb_rd,
    input  logic wb_write,
    input  logic [rv_isa_pkg::XLEN-1:0] wb_result,
    output logic [rv_isa_pkg::XLEN-1:0] src_a,
    output logic [rv_isa_pkg::XLEN-1:0] src_b
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic [FWD_SEL_W-1:0] sel_a;
    logic [FWD_SEL_W-1:0] sel_b;

    // Younger producer wins
    function automatic logic [FWD_SEL_W-1:0] fwd_sel(input logic [REG_ADDR_W-1:0] src);
        if (src == '0) begin
            return FWD_REG;
        end
        if (mem_write && mem_rd == src) begin
            return FWD_MEM;
        end
        if (wb_write && wb_rd == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    function automatic logic [XLEN-1:0] fwd_pick(input logic [FWD_SEL_W-1:0] sel,
                                                 input logic [XLEN-1:0] reg_data);
        case (sel)
            FWD_MEM: return mem_result;
            FWD_WB: return wb_result;
            default: return reg_data;
        endcase
    endfunction

    always_comb begin
        sel_a = fwd_sel(ex_rs1);
        sel_b = fwd_sel(ex_rs2);
        src_a = fwd_pick(sel_a, ex_rd1);
        src_b = ex_use_imm ? ex_imm : fwd_pick(sel_b, ex_rd2);
    end

endmodule

`default_nettype wire

/* instr_decoder.sv */
`default_nettype none
`timescale 1ns/100ps

module instr_decoder (
    input  rv_isa_pkg::instr_u instr,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] rd,
    output logic [rv_isa_pkg::XLEN-1:0] imm,
    output logic [pipe_pkg::ALU_OP_W-1:0] alu_op,
    output logic use_imm,
    output logic reg_write,
    output logic illegal
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic is_op;
    logic is_op_imm;
    logic alt_bit;

    assign is_op = (instr.r.opcode == OPCODE_OP);
    assign is_op_imm = (instr.i.opcode == OPCODE_OP_IMM);

    assign illegal = !(is_op || is_op_imm);
    assign reg_write = !illegal;
    assign use_imm = is_op_imm;

    assign rs1 = instr.r.rs1;
    assign rs2 = instr.r.rs2;
    // A bubble names no destination
    assign rd = illegal ? '0 : instr.r.rd;

    assign imm = {{(XLEN - 12){instr.i.imm12[11]}}, instr.i.imm12};

    // Instruction bit 30 in both formats
    assign alt_bit = instr.r.funct7[5];

    always_comb begin
        case (instr.r.funct3)
            FUNCT3_ADD_SUB: begin
                // No subi in RV32I
                alu_op = (is_op && alt_bit) ? ALU_SUB : ALU_ADD;
            end
            FUNCT3_SLL: alu_op = ALU_SLL;
            FUNCT3_SLT: alu_op = ALU_SLT;
            FUNCT3_SLTU: alu_op = ALU_SLTU;
            FUNCT3_XOR: alu_op = ALU_XOR;
            FUNCT3_SRL_SRA: begin
                alu_op = alt_bit ? ALU_SRA : ALU_SRL;
            end
            FUNCT3_OR: alu_op = ALU_OR;
            FUNCT3_AND: alu_op = ALU_AND;
            default: alu_op = ALU_ADD;
        endcase
    end

endmodule

`default_nettype wire

/* int_pipeline.sv */
`default_nettype none
`timescale 1ns/100ps

module int_pipeline (
    input  logic clk,
    input  logic reset,
    input  logic instr_valid,
    input  rv_isa_pkg::instr_u instr,
    output logic retire_valid,
    output logic retire_illegal,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] retire_rd,
    output logic [rv_isa_pkg::XLEN-1:0] retire_data,
    output rv_isa_pkg::instr_u retire_instruction
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    // ID stage
    logic id_valid;
    instr_u id_instr;
    logic [REG_ADDR_W-1:0] dec_rs1;
    logic [REG_ADDR_W-1:0] dec_rs2;
    logic [REG_ADDR_W-1:0] dec_rd;
    logic [XLEN-1:0] dec_imm;
    logic [ALU_OP_W-1:0] dec_alu_op;
    logic dec_use_imm;
    logic dec_reg_write;
    logic dec_illegal;
    logic [XLEN-1:0] rf_data_a;
    logic [XLEN-1:0] rf_data_b;

    // EX stage
    logic ex_valid;
    logic ex_write;
    logic ex_illegal;
    instr_u ex_instr;
    logic [REG_ADDR_W-1:0] ex_rs1;
    logic [REG_ADDR_W-1:0] ex_rs2;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic [XLEN-1:0] ex_rd1;
    logic [XLEN-1:0] ex_rd2;
    logic [XLEN-1:0] ex_imm;
    logic ex_use_imm;
    logic [ALU_OP_W-1:0] ex_alu_op;
    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] alu_result;

    // MEM and WB stages
    logic mem_valid;
    logic mem_write;
    logic mem_illegal;
    instr_u mem_instr;
    logic [REG_ADDR_W-1:0] mem_rd;
    logic [XLEN-1:0] mem_result;
    logic wb_valid;
    logic wb_write;
    logic wb_illegal;
    instr_u wb_instr;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0] wb_result;

    instr_decoder i_instr_decoder (
        .instr(id_instr),
        .rs1(dec_rs1),
        .rs2(dec_rs2),
        .rd(dec_rd),
        .imm(dec_imm),
        .alu_op(dec_alu_op),
        .use_imm(dec_use_imm),
        .reg_write(dec_reg_write),
        .illegal(dec_illegal)
    );

    register_file i_register_file (
        .clk(clk),
        .reset(reset),
        .read_addr_a(dec_rs1),
        .read_addr_b(dec_rs2),
        .write_addr(wb_rd),
        .write_data(wb_result),
        .write_enable(wb_write),
        .read_data_a(rf_data_a),
        .read_data_b(rf_data_b)
    );

    forward_unit i_forward_unit (
        .ex_rs1(ex_rs1),
        .ex_rs2(ex_rs2),
        .ex_rd1(ex_rd1),
        .ex_rd2(ex_rd2),
        .ex_imm(ex_imm),
        .ex_use_imm(ex_use_imm),
        .mem_rd(mem_rd),
        .mem_write(mem_write),
        .mem_result(mem_result),
        .wb_rd(wb_rd),
        .wb_write(wb_write),
        .wb_result(wb_result),
        .src_a(src_a),
        .src_b(src_b)
    );

    alu i_alu (
        .src_a(src_a),
        .src_b(src_b),
        .alu_op(ex_alu_op),
        .result(alu_result)
    );

    // Valid bits and write enables
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_valid <= 1'b0;
            ex_valid <= 1'b0;
            ex_write <= 1'b0;
            ex_illegal <= 1'b0;
            mem_valid <= 1'b0;
            mem_write <= 1'b0;
            mem_illegal <= 1'b0;
            wb_valid <= 1'b0;
            wb_write <= 1'b0;
            wb_illegal <= 1'b0;
        end else begin
            id_valid <= instr_valid;
            ex_valid <= id_valid;
            ex_write <= id_valid && dec_reg_write;
            ex_illegal <= id_valid && dec_illegal;
            mem_valid <= ex_valid;
            mem_write <= ex_write;
            mem_illegal <= ex_illegal;
            wb_valid <= mem_valid;
            wb_write <= mem_write;
            wb_illegal <= mem_illegal;
        end
    end

    always_ff @(posedge clk) begin
        id_instr <= instr;
        ex_instr <= id_instr;
        ex_rs1 <= dec_rs1;
        ex_rs2 <= dec_rs2;
        ex_rd <= dec_rd;
        ex_rd1 <= rf_data_a;
        ex_rd2 <= rf_data_b;
        ex_imm <= dec_imm;
        ex_use_imm <= dec_use_imm;
        ex_alu_op <= dec_alu_op;
        mem_instr <= ex_instr;
        mem_rd <= ex_rd;
        // Bubbles carry a zero result
        mem_result <= ex_illegal ? '0 : alu_result;
        wb_instr <= mem_instr;
        wb_rd <= mem_rd;
        wb_result <= mem_result;
    end

    assign retire_valid = wb_valid;
    assign retire_illegal = wb_illegal;
    assign retire_rd = wb_rd;
    assign retire_data = wb_result;
    assign retire_instruction = wb_instr;

endmodule

`default_nettype wire

/* int_pipeline_props.sv */
`default_nettype none
`timescale 1ns/100ps

module int_pipeline_props (
    input logic clk,
    input logic reset,
    input logic instr_valid,
    input logic retire_valid,
    input logic retire_illegal,
    input logic [rv_isa_pkg::REG_ADDR_W-1:0] retire_rd,
    input logic [rv_isa_pkg::XLEN-1:0] retire_data,
    input rv_isa_pkg::instr_u retire_instruction
);
    import rv_isa_pkg::*;

    localparam int RETIRE_LATENCY = 4;

    illegal_needs_valid: assert property (@(posedge clk) disable iff (reset)
        retire_illegal |-> retire_valid)
        else $error("retire_illegal high without retire_valid");

    // Fixed latency from the sampling edge
    retire_follows_issue: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> $past(instr_valid, RETIRE_LATENCY))
        else $error("retire_valid without instr_valid %0d cycles earlier", RETIRE_LATENCY);

    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !retire_valid)
        else $error("retire_valid high right after reset release");

    legal_rd_matches_word: assert property (@(posedge clk) disable iff (reset)
        (retire_valid && !retire_illegal) |-> retire_rd == retire_instruction.r.rd)
        else $error("retire_rd differs from the rd field of retire_instruction");

    bubble_is_empty: assert property (@(posedge clk) disable iff (reset)
        retire_illegal |-> (retire_rd == '0 && retire_data == '0))
        else $error("illegal retire carries a destination or data");

endmodule

bind int_pipeline int_pipeline_props i_int_pipeline_props (
    .clk(clk),
    .reset(reset),
    .instr_valid(instr_valid),
    .retire_valid(retire_valid),
    .retire_illegal(retire_illegal),
    .retire_rd(retire_rd),
    .retire_data(retire_data),
    .retire_instruction(retire_instruction)
);

`default_nettype wire

/* int_pipeline_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module int_pipeline_tb;
    import rv_isa_pkg::*;

    localparam int RETIRE_LATENCY = 4;
    localparam int DRAIN_TIMEOUT = 200;
    localparam string CASE_FILE = "pipeline_cases.txt";

    logic clk;
    logic reset;
    logic instr_valid;
    instr_u instr;
    logic retire_valid;
    logic retire_illegal;
    logic [REG_ADDR_W-1:0] retire_rd;
    logic [XLEN-1:0] retire_data;
    instr_u retire_instruction;

    // Records from the case file
    logic [XLEN-1:0] case_instr[$];
    logic [REG_ADDR_W-1:0] case_rd[$];
    logic [XLEN-1:0] case_data[$];
    logic case_illegal[$];

    // Outstanding instructions, oldest first
    logic [XLEN-1:0] exp_instr[$];
    logic [REG_ADDR_W-1:0] exp_rd[$];
    logic [XLEN-1:0] exp_data[$];
    logic exp_illegal[$];
    int exp_cycle[$];

    int cycle_count = 0;
    int retired = 0;
    int value_errors = 0;
    int stray_errors = 0;
    int run_errors = 0;
    int unsigned lcg_state = 71;

    int_pipeline i_int_pipeline (
        .clk(clk),
        .reset(reset),
        .instr_valid(instr_valid),
        .instr(instr),
        .retire_valid(retire_valid),
        .retire_illegal(retire_illegal),
        .retire_rd(retire_rd),
        .retire_data(retire_data),
        .retire_instruction(retire_instruction)
    );

    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Mostly back-to-back, sometimes one or two idle cycles
    function automatic int idle_cycles(input int unsigned state);
        logic [1:0] pick;
        pick = state[17:16];
        if (pick == 2'd3) begin
            return 2;
        end
        return (pick == 2'd2) ? 1 : 0;
    endfunction

    task automatic check_word(input string name, input logic [XLEN-1:0] actual,
                              input logic [XLEN-1:0] expected);
        if (actual !== expected) begin
            value_errors++;
            $display("FAIL %0t %s: got %08h, expected %08h", $time, name, actual, expected);
        end
    endtask

    task automatic check_reg(input string name, input logic [REG_ADDR_W-1:0] actual,
                             input logic [REG_ADDR_W-1:0] expected);
        if (actual !== expected) begin
            value_errors++;
            $display("FAIL %0t %s: got x%0d, expected x%0d", $time, name, actual, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            value_errors++;
            $display("FAIL %0t %s: got %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic check_latency(input string name, input int actual, input int expected);
        if (actual != expected) begin
            value_errors++;
            $display("FAIL %0t %s: got %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Retire monitor, sampled away from the active edge
    always @(negedge clk) begin
        if (!reset && retire_valid === 1'b1) begin
            retired++;
            if (exp_instr.size() == 0) begin
                stray_errors++;
                $display("Error at %0t: a retire came out with no instruction in flight", $time);
            end else begin
                check_word("retire_instruction", retire_instruction, exp_instr.pop_front());
                check_reg("retire_rd", retire_rd, exp_rd.pop_front());
                check_word("retire_data", retire_data, exp_data.pop_front());
                check_flag("retire_illegal", retire_illegal, exp_illegal.pop_front());
                check_latency("retire latency", cycle_count - exp_cycle.pop_front(),
                              RETIRE_LATENCY);
            end
        end
    end

    initial begin
        int fd;
        int fields;
        int gap;
        int wait_cycles;
        string line;
        logic [31:0] f_instr;
        logic [31:0] f_rd;
        logic [31:0] f_data;
        logic [31:0] f_ill;

        reset = 1'b1;
        instr_valid = 1'b0;
        instr = '0;

        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            run_errors++;
            $display("Error: the case file %s could not be opened", CASE_FILE);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                fields = $sscanf(line, "%h %h %h %h", f_instr, f_rd, f_data, f_ill);
                if (fields == 4) begin
                    case_instr.push_back(f_instr);
                    case_rd.push_back(f_rd[REG_ADDR_W-1:0]);
                    case_data.push_back(f_data);
                    case_illegal.push_back(f_ill[0]);
                end
            end
            $fclose(fd);
        end
        if (fd != 0 && case_instr.size() == 0) begin
            run_errors++;
            $display("Error: the case file holds no records");
        end

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < case_instr.size(); i++) begin
            instr_valid = 1'b1;
            instr = case_instr[i];
            exp_instr.push_back(case_instr[i]);
            exp_rd.push_back(case_rd[i]);
            exp_data.push_back(case_data[i]);
            exp_illegal.push_back(case_illegal[i]);
            exp_cycle.push_back(cycle_count);
            @(posedge clk);
            #1;
            instr_valid = 1'b0;
            instr = '0;
            lcg_state = lcg_next(lcg_state);
            gap = idle_cycles(lcg_state);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end

        wait_cycles = 0;
        while (exp_instr.size() != 0 && wait_cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (exp_instr.size() != 0) begin
            run_errors++;
            $display("Error: timed out with %0d instructions never retired", exp_instr.size());
        end

        // Room for any extra retire to show up
        repeat (RETIRE_LATENCY + 2) @(posedge clk);

        $display("Retired %0d of %0d, errors: %0d value, %0d stray retire, %0d run",
                 retired, case_instr.size(), value_errors, stray_errors, run_errors);
        if (value_errors == 0 && stray_errors == 0 && run_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    localparam int ALU_OP_W = 4;

    localparam logic [ALU_OP_W-1:0] ALU_ADD = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLL = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLT = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_XOR = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_OR = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_AND = 4'd9;

    localparam int FWD_SEL_W = 2;

    // EX operand source
    localparam logic [FWD_SEL_W-1:0] FWD_REG = 2'd0;
    localparam logic [FWD_SEL_W-1:0] FWD_MEM = 2'd1;
    localparam logic [FWD_SEL_W-1:0] FWD_WB = 2'd2;

endpackage

`default_nettype wire

/* pipeline_cases.txt */
// Columns, all hex: instruction word, expected rd, expected data, illegal flag
// Program order; every register starts at zero
06400093 01 00000064 0  // addi x1, x0, 100
ff900113 02 fffffff9 0  // addi x2, x0, -7
002081b3 03 0000005d 0  // add x3, x1, x2
40208233 04 0000006b 0  // sub x4, x1, x2
001122b3 05 00000001 0  // slt x5, x2, x1
00113333 06 00000000 0  // sltu x6, x2, x1
fff12393 07 00000001 0  // slti x7, x2, -1
fff0b413 08 00000001 0  // sltiu x8, x1, -1
0020c4b3 09 ffffff9d 0  // xor x9, x1, x2
0ff0c513 0a 0000009b 0  // xori x10, x1, 0xff
0020e5b3 0b fffffffd 0  // or x11, x1, x2
55506613 0c 00000555 0  // ori x12, x0, 0x555
002676b3 0d 00000551 0  // and x13, x12, x2
0f017713 0e 000000f0 0  // andi x14, x2, 0xf0
003097b3 0f 80000000 0  // sll x15, x1, x3
00409813 10 00000640 0  // slli x16, x1, 4
004158b3 11 001fffff 0  // srl x17, x2, x4
40415933 12 ffffffff 0  // sra x18, x2, x4
01c7d993 13 00000008 0  // srli x19, x15, 28
41c7da13 14 fffffff8 0  // srai x20, x15, 28
00508013 00 00000069 0  // addi x0, x1, 5
00000ab3 15 00000000 0  // add x21, x0, x0
00012083 00 00000000 1  // lw x1, 0(x2)
00008b13 16 00000064 0  // addi x22, x1, 0
016b0bb3 17 000000c8 0  // add x23, x22, x22
416b8c33 18 00000064 0  // sub x24, x23, x22

/* project.f */
rv_isa_pkg.sv
pipe_pkg.sv
instr_decoder.sv
register_file.sv
alu.sv
forward_unit.sv
int_pipeline.sv
int_pipeline_props.sv
int_pipeline_tb.sv

/* register_file.sv */
`default_nettype none
`timescale 1ns/100ps

module register_file (
    input  logic clk,
    input  logic reset,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] read_addr_a,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] read_addr_b,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] write_addr,
    input  logic [rv_isa_pkg::XLEN-1:0] write_data,
    input  logic write_enable,
    output logic [rv_isa_pkg::XLEN-1:0] read_data_a,
    output logic [rv_isa_pkg::XLEN-1:0] read_data_b
);
    import rv_isa_pkg::*;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:NUM_REGS-1];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_addr != '0) begin
            regs[write_addr] <= write_data;
        end
    end

    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        // Same-cycle write passes straight through
        if (write_enable && addr == write_addr) begin
            return write_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        read_data_a = read_port(read_addr_a);
        read_data_b = read_port(read_addr_b);
    end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the integer pipeline testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir="obj_dir"
sim_name="int_pipeline_sim"
log_file="sim.log"

verilator --binary --timing --assert --top-module int_pipeline_tb \
    -f project.f --Mdir "$build_dir" -o "$sim_name"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/$sim_name" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Verification passed" "$log_file"; then
    echo "Result: PASS"
    exit 0
fi
echo "Result: FAIL"
exit 1

/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS = 32;

    // Opcodes handled by the pipeline
    localparam logic [6:0] OPCODE_OP = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL = 3'b001;
    localparam logic [2:0] FUNCT3_SLT = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU = 3'b011;
    localparam logic [2:0] FUNCT3_XOR = 3'b100;
    localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
    localparam logic [2:0] FUNCT3_OR = 3'b110;
    localparam logic [2:0] FUNCT3_AND = 3'b111;

    // One instruction word seen as R-type or I-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            // Holds shamt and the sra bit for shifts
            logic [11:0] imm12;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } i;
    } instr_u;

endpackage

`default_nettype wire
